// ==== hw/dcache_pkg.sv ====
// Fixed geometry of 2 ways, 16 sets and 4-word lines; changing a width here changes every module
package dcache_pkg;

    localparam int word_w = 32;
    localparam int set_idx_w = 4;
    localparam int word_off_w = 2;
    localparam int byte_off_w = 2;
    localparam int tag_w = word_w - set_idx_w - word_off_w - byte_off_w;
    localparam int words_per_line = 4;
    localparam int num_sets = 2 ** set_idx_w;
    // One LRU bit per set only covers two ways
    localparam int num_ways = 2;

    // Same processor word seen as a flat address or as lookup fields
    typedef union packed {
        logic [word_w-1:0] raw;
        struct packed {
            logic [tag_w-1:0]      tag;
            logic [set_idx_w-1:0]  set_idx;
            logic [word_off_w-1:0] word_off;
            logic [byte_off_w-1:0] byte_off;
        } fields;
    } dcache_addr_u;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic             valid;
        logic             dirty;
    } dcache_meta_t;

    typedef logic [words_per_line-1:0][word_w-1:0] dcache_line_t;

endpackage

// ==== hw/dcache_way_if.sv ====
// One way's lookup and update bundle; the read side lags index by one clock
`timescale 1ns/100ps

interface dcache_way_if;

    logic [dcache_pkg::set_idx_w-1:0] index;
    logic                             wen;
    dcache_pkg::dcache_line_t         wline;
    dcache_pkg::dcache_meta_t         wmeta;
    dcache_pkg::dcache_line_t         rline;
    dcache_pkg::dcache_meta_t         rmeta;
    logic                             hit;
    logic [dcache_pkg::tag_w-1:0]     lookup_tag;

    modport ctrl (
        output index, wen, wline, wmeta, lookup_tag
    );

    modport way (
        input  index, wen, wline, wmeta, lookup_tag,
        output rline, rmeta, hit
    );

    modport sel (
        input rline, rmeta, hit
    );

endinterface

// ==== hw/dcache_way.sv ====
// Register-based way storage; a write in the same cycle as a read returns the new line
`timescale 1ns/100ps

module dcache_way (
    input logic clk,
    input logic nrst,
    dcache_way_if.way w
);

    logic [dcache_pkg::tag_w-1:0]  tag_mem [dcache_pkg::num_sets];
    dcache_pkg::dcache_line_t      line_mem [dcache_pkg::num_sets];
    logic [dcache_pkg::num_sets-1:0] valid_q;
    logic [dcache_pkg::num_sets-1:0] dirty_mem;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            valid_q <= '0;
        end else if (w.wen) begin
            valid_q[w.index] <= w.wmeta.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (w.wen) begin
            tag_mem[w.index]   <= w.wmeta.tag;
            dirty_mem[w.index] <= w.wmeta.dirty;
            line_mem[w.index]  <= w.wline;
        end
    end

    // Registered read, forwarding the written line so the fill can merge word by word
    always_ff @(posedge clk) begin
        if (w.wen) begin
            w.rline <= w.wline;
            w.rmeta <= w.wmeta;
        end else begin
            w.rline       <= line_mem[w.index];
            w.rmeta.tag   <= tag_mem[w.index];
            w.rmeta.valid <= valid_q[w.index];
            w.rmeta.dirty <= dirty_mem[w.index];
        end
    end

    assign w.hit = w.rmeta.valid && (w.rmeta.tag == w.lookup_tag);

endmodule

// ==== hw/dcache_victim_select.sv ====
// Purely combinational; the victim stays put during a fill only while its metadata is unchanged
`timescale 1ns/100ps

module dcache_victim_select (
    dcache_way_if.sel                ways [dcache_pkg::num_ways],
    output logic                     hit_any,
    output logic                     hit_way,
    input  logic                     lru_way,
    output logic                     victim_way,
    output dcache_pkg::dcache_line_t hit_line,
    output dcache_pkg::dcache_line_t victim_line,
    output dcache_pkg::dcache_meta_t victim_meta
);

    logic [dcache_pkg::num_ways-1:0] hits;
    dcache_pkg::dcache_line_t        lines [dcache_pkg::num_ways];
    dcache_pkg::dcache_meta_t        metas [dcache_pkg::num_ways];

    // Per-way hit, line and metadata as plain arrays
    for (genvar g = 0; g < dcache_pkg::num_ways; g++) begin : g_unpack
        assign hits[g]  = ways[g].hit;
        assign lines[g] = ways[g].rline;
        assign metas[g] = ways[g].rmeta;
    end

    assign hit_any = |hits;
    // Tags are unique within a set, so at most one way hits
    assign hit_way = hits[1];

    // Empty way first, then the least recently used one
    assign victim_way = !metas[0].valid ? 1'b0 :
                        !metas[1].valid ? 1'b1 : lru_way;

    assign hit_line    = lines[hit_way];
    assign victim_line = lines[victim_way];
    assign victim_meta = metas[victim_way];

endmodule

// ==== hw/dcache_ctrl.sv ====
// One access at a time; cpu_addr and cpu_store must stay steady until cpu_done
`timescale 1ns/100ps

module dcache_ctrl (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            cpu_read,
    input  logic                            cpu_write,
    input  logic                            cpu_done,
    input  logic [dcache_pkg::word_w-1:0]   cpu_addr,
    input  logic [dcache_pkg::word_w-1:0]   cpu_store,
    output logic                            cpu_ready,
    output logic [dcache_pkg::word_w-1:0]   cpu_load,
    output logic                            mem_read,
    output logic                            mem_write,
    output logic                            mem_done,
    output logic [dcache_pkg::word_w-1:0]   mem_addr,
    output logic [dcache_pkg::word_w-1:0]   mem_store,
    input  logic                            mem_ready,
    input  logic [dcache_pkg::word_w-1:0]   mem_load,
    dcache_way_if.ctrl                      ways [dcache_pkg::num_ways],
    input  logic                            hit_any,
    input  logic                            hit_way,
    input  logic                            victim_way,
    input  dcache_pkg::dcache_line_t        hit_line,
    input  dcache_pkg::dcache_line_t        victim_line,
    input  dcache_pkg::dcache_meta_t        victim_meta,
    output logic                            lru_way
);

    // Low two bits of the fill and write-back states are the word number
    typedef enum logic [3:0] {
        st_idle  = 4'b0000,
        st_check = 4'b0001,
        st_rd0   = 4'b0100,
        st_rd1,
        st_rd2,
        st_rd3,
        st_wb0   = 4'b1000,
        st_wb1,
        st_wb2,
        st_wb3
    } state_t;

    state_t state;
    state_t next_state;

    dcache_pkg::dcache_addr_u cpu_a;
    dcache_pkg::dcache_addr_u mem_a;
    logic [dcache_pkg::num_sets-1:0] lru_q;
    logic [dcache_pkg::word_off_w-1:0] word;

    logic                     wen;
    logic                     wsel;
    dcache_pkg::dcache_line_t wline;
    dcache_pkg::dcache_meta_t wmeta;
    logic                     lru_upd;
    logic                     lru_new;

    assign cpu_a.raw = cpu_addr;
    assign word = state[1:0];
    assign lru_way = lru_q[cpu_a.fields.set_idx];
    assign mem_addr = mem_a.raw;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            lru_q <= '0;
        end else if (lru_upd) begin
            lru_q[cpu_a.fields.set_idx] <= lru_new;
        end
    end

    always_comb begin
        next_state = state;
        cpu_ready  = 1'b0;
        cpu_load   = hit_line[cpu_a.fields.word_off];
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_done   = 1'b0;
        // Line base of the request plus the current word
        mem_a                 = cpu_a;
        mem_a.fields.word_off = word;
        mem_a.fields.byte_off = '0;
        mem_store  = victim_line[word];
        wen        = 1'b0;
        wsel       = victim_way;
        wline      = victim_line;
        wmeta      = victim_meta;
        lru_upd    = 1'b0;
        lru_new    = ~hit_way;

        case (state)
            st_idle: begin
                if (cpu_read || cpu_write) begin
                    next_state = st_check;
                end
            end

            st_check: begin
                if (hit_any) begin
                    cpu_ready = 1'b1;
                    wsel      = hit_way;
                    if (cpu_done) begin
                        next_state = st_idle;
                        lru_upd    = 1'b1;
                        if (cpu_write) begin
                            wen   = 1'b1;
                            wline = hit_line;
                            wline[cpu_a.fields.word_off] = cpu_store;
                            wmeta.tag   = cpu_a.fields.tag;
                            wmeta.valid = 1'b1;
                            wmeta.dirty = 1'b1;
                        end
                    end
                end else if (victim_meta.valid && victim_meta.dirty) begin
                    next_state = st_wb0;
                end else begin
                    next_state = st_rd0;
                end
            end

            st_rd0, st_rd1, st_rd2, st_rd3: begin
                mem_read = 1'b1;
                if (mem_ready) begin
                    mem_done    = 1'b1;
                    wen         = 1'b1;
                    wline[word] = mem_load;
                    if (state == st_rd3) begin
                        // Tag goes in only with the last word, which keeps the victim choice stable
                        wmeta.tag   = cpu_a.fields.tag;
                        wmeta.valid = 1'b1;
                        wmeta.dirty = 1'b0;
                        // A write finishes as a hit from check
                        next_state = st_check;
                        if (cpu_read) begin
                            cpu_ready = 1'b1;
                            // Requested word of the line just merged with the last memory word
                            cpu_load  = wline[cpu_a.fields.word_off];
                            if (cpu_done) begin
                                next_state = st_idle;
                                lru_upd    = 1'b1;
                                lru_new    = ~victim_way;
                            end
                        end
                    end else begin
                        next_state = state_t'(state + 4'd1);
                    end
                end
            end

            st_wb0, st_wb1, st_wb2, st_wb3: begin
                mem_write = 1'b1;
                // Victim line goes back to its own address
                mem_a.fields.tag = victim_meta.tag;
                if (mem_ready) begin
                    mem_done = 1'b1;
                    if (state == st_wb3) begin
                        next_state = st_rd0;
                    end else begin
                        next_state = state_t'(state + 4'd1);
                    end
                end
            end

            default: begin
                next_state = st_idle;
            end
        endcase
    end

    for (genvar g = 0; g < dcache_pkg::num_ways; g++) begin : g_way_drive
        assign ways[g].index      = cpu_a.fields.set_idx;
        assign ways[g].lookup_tag = cpu_a.fields.tag;
        assign ways[g].wen        = wen && (wsel == 1'(g));
        assign ways[g].wline      = wline;
        assign ways[g].wmeta      = wmeta;
    end

endmodule

// ==== hw/dcache_top.sv ====
// Two-way write-back data cache; word-serial memory side, no flush and no byte enables
`timescale 1ns/100ps

module dcache_top (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          cpu_read,
    input  logic                          cpu_write,
    input  logic                          cpu_done,
    input  logic [dcache_pkg::word_w-1:0] cpu_addr,
    input  logic [dcache_pkg::word_w-1:0] cpu_store,
    output logic                          cpu_ready,
    output logic [dcache_pkg::word_w-1:0] cpu_load,
    output logic                          mem_read,
    output logic                          mem_write,
    output logic                          mem_done,
    output logic [dcache_pkg::word_w-1:0] mem_addr,
    output logic [dcache_pkg::word_w-1:0] mem_store,
    input  logic                          mem_ready,
    input  logic [dcache_pkg::word_w-1:0] mem_load
);

    dcache_way_if way_bus [dcache_pkg::num_ways] ();

    logic                     hit_any;
    logic                     hit_way;
    logic                     victim_way;
    logic                     lru_way;
    dcache_pkg::dcache_line_t hit_line;
    dcache_pkg::dcache_line_t victim_line;
    dcache_pkg::dcache_meta_t victim_meta;

    dcache_ctrl i_ctrl (
        .clk         (clk),
        .nrst        (nrst),
        .cpu_read    (cpu_read),
        .cpu_write   (cpu_write),
        .cpu_done    (cpu_done),
        .cpu_addr    (cpu_addr),
        .cpu_store   (cpu_store),
        .cpu_ready   (cpu_ready),
        .cpu_load    (cpu_load),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_done    (mem_done),
        .mem_addr    (mem_addr),
        .mem_store   (mem_store),
        .mem_ready   (mem_ready),
        .mem_load    (mem_load),
        .ways        (way_bus),
        .hit_any     (hit_any),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .hit_line    (hit_line),
        .victim_line (victim_line),
        .victim_meta (victim_meta),
        .lru_way     (lru_way)
    );

    for (genvar g = 0; g < dcache_pkg::num_ways; g++) begin : g_way
        dcache_way i_way (
            .clk  (clk),
            .nrst (nrst),
            .w    (way_bus[g])
        );
    end

    dcache_victim_select i_sel (
        .ways        (way_bus),
        .hit_any     (hit_any),
        .hit_way     (hit_way),
        .lru_way     (lru_way),
        .victim_way  (victim_way),
        .hit_line    (hit_line),
        .victim_line (victim_line),
        .victim_meta (victim_meta)
    );

endmodule

// ==== tb/mem_model.sv ====
// Unwritten words read as address XOR 32'h5a5a_0f0f; each word is answered 1 to 4 cycles late
`timescale 1ns/100ps

module mem_model (
    input  logic        clk,
    input  logic        nrst,
    input  logic        mem_read,
    input  logic        mem_write,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_store,
    output logic        mem_ready,
    output logic [31:0] mem_load,
    input  logic        count_clr,
    output logic [31:0] rd_count,
    output logic [31:0] wr_count
);

    logic [31:0] words [logic [31:0]];
    int          seed = 32'h6a0d_c986;
    logic        busy;
    logic [1:0]  delay;

    always @(posedge clk) begin
        if (!nrst) begin
            mem_ready <= 1'b0;
            mem_load  <= '0;
            busy      <= 1'b0;
            delay     <= 2'd0;
            rd_count  <= '0;
            wr_count  <= '0;
        end else begin
            mem_ready <= 1'b0;
            if (count_clr) begin
                rd_count <= '0;
                wr_count <= '0;
            end
            if (mem_ready) begin
                // Cache steps to its next word on this edge
                busy <= 1'b0;
            end else if (!busy && (mem_read || mem_write)) begin
                busy  <= 1'b1;
                delay <= 2'($random(seed));
            end else if (busy && delay != 2'd0) begin
                delay <= delay - 2'd1;
            end else if (busy) begin
                mem_ready <= 1'b1;
                if (mem_write) begin
                    words[mem_addr] = mem_store;
                    wr_count <= wr_count + 1;
                end else begin
                    mem_load <= words.exists(mem_addr) ? words[mem_addr]
                                                       : mem_addr ^ 32'h5a5a_0f0f;
                    rd_count <= rd_count + 1;
                end
            end
        end
    end

endmodule

// ==== tb/tb_dcache.sv ====
// Directed LRU and eviction cases then 40 random accesses; stops at the first mismatch
`timescale 1ns/100ps

module tb_dcache;

    localparam int timeout_cycles = 20000;

    logic        clk, nrst;
    logic        cpu_read, cpu_write, cpu_done, cpu_ready;
    logic [31:0] cpu_addr, cpu_store, cpu_load;
    logic        mem_read, mem_write, mem_done, mem_ready;
    logic [31:0] mem_addr, mem_store, mem_load;
    logic        count_clr;
    logic [31:0] rd_count, wr_count;

    // Every processor write, over the memory's initial pattern
    logic [31:0] ref_mem [logic [31:0]];
    logic        wb_line_en;
    logic [31:0] wb_line;
    logic [1:0]  rd_idx, wr_idx;
    int          seed = 32'h6a0d_c986;
    int          cycle_cnt = 0;

    dcache_top i_dut (.*);
    mem_model  i_mem (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Timeout: access sequence still running after %0d cycles", cycle_cnt);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return addr ^ 32'h5a5a_0f0f;
    endfunction

    task automatic compare_word(input string sig, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %0t %s expected 0x%08h got 0x%08h", $time, sig, exp, act);
            $display("TB FAILED");
            $fatal(1, "%s mismatch", sig);
        end
    endtask

    // One full processor handshake; latency counts cycles from request to cpu_ready
    task automatic access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                          output int lat, output logic [31:0] rdc, output logic [31:0] wrc);
        int n;
        @(posedge clk);
        cpu_read  <= ~wr;
        cpu_write <= wr;
        cpu_addr  <= addr;
        cpu_store <= data;
        count_clr <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!cpu_ready);
        lat = n - 1;
        rdc = rd_count;
        wrc = wr_count;
        if (!wr) begin
            compare_word("cpu_load", ref_word(addr), cpu_load);
        end
        @(posedge clk);
        cpu_done <= 1'b1;
        @(posedge clk);
        cpu_done  <= 1'b0;
        cpu_read  <= 1'b0;
        cpu_write <= 1'b0;
        count_clr <= 1'b1;
        if (wr) begin
            ref_mem[addr] = data;
        end
    endtask

    task automatic hit_access(input logic wr, input logic [31:0] addr, input logic [31:0] data);
        int          lat;
        logic [31:0] rdc;
        logic [31:0] wrc;
        access(wr, addr, data, lat, rdc, wrc);
        compare_word("cpu_ready latency", 1, lat);
        compare_word("mem reads", 0, rdc);
        compare_word("mem writes", 0, wrc);
    endtask

    task automatic miss_access(input logic [31:0] addr, input logic [31:0] wb_words);
        int          lat;
        logic [31:0] rdc;
        logic [31:0] wrc;
        access(1'b0, addr, 32'd0, lat, rdc, wrc);
        compare_word("mem reads", 4, rdc);
        compare_word("mem writes", wb_words, wrc);
    endtask

    // Memory side checks fill order, write-back order and write-back data
    always @(negedge clk) begin
        if (!nrst || cpu_done) begin
            rd_idx = 2'd0;
            wr_idx = 2'd0;
        end else begin
            compare_word("mem_done", {31'd0, mem_ready}, {31'd0, mem_done});
            compare_word("mem_read & mem_write", 0, {31'd0, mem_read & mem_write});
            if (mem_done && mem_read) begin
                compare_word("mem_addr", {cpu_addr[31:4], rd_idx, 2'b00}, mem_addr);
                rd_idx = rd_idx + 2'd1;
            end
            if (mem_done && mem_write) begin
                compare_word("mem reads before write-back", 0, {30'd0, rd_idx});
                if (wb_line_en) begin
                    compare_word("mem_addr", {wb_line[31:8], cpu_addr[7:4], wr_idx, 2'b00},
                                 mem_addr);
                end else begin
                    compare_word("mem_addr[7:0]", {24'd0, cpu_addr[7:4], wr_idx, 2'b00},
                                 {24'd0, mem_addr[7:0]});
                end
                compare_word("mem_store", ref_word(mem_addr), mem_store);
                wr_idx = wr_idx + 2'd1;
            end
        end
    end

    initial begin
        int          lat;
        logic [31:0] rdc, wrc, r, addr, data, a, b, c;
        logic [1:0]  tsel;
        nrst       = 1'b0;
        cpu_read   = 1'b0;
        cpu_write  = 1'b0;
        cpu_done   = 1'b0;
        cpu_addr   = '0;
        cpu_store  = '0;
        count_clr  = 1'b0;
        wb_line_en = 1'b0;
        wb_line    = '0;
        // Three tags that share set 3
        a = 32'h0001_0030;
        b = 32'h0002_0030;
        c = 32'h0003_0030;
        repeat (4) @(posedge clk);
        nrst <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            compare_word("cpu_ready/mem_read/mem_write/mem_done", 0,
                         {28'd0, cpu_ready, mem_read, mem_write, mem_done});
        end

        miss_access(a + 4, 0);
        for (int w = 0; w < 4; w++) begin
            hit_access(1'b0, a + 32'(4 * w), 32'd0);
        end
        miss_access(b, 0);
        // Write hit dirties A and leaves B as LRU
        hit_access(1'b1, a + 8, 32'hcafe_0008);
        hit_access(1'b0, a + 8, 32'd0);
        miss_access(c, 0);
        wb_line    = a;
        wb_line_en = 1'b1;
        miss_access(b + 4, 4);
        wb_line_en = 1'b0;
        // C is LRU and clean, so A's stored word comes back from memory
        miss_access(a + 8, 0);

        for (int i = 0; i < 40; i++) begin
            r    = $random(seed);
            tsel = 2'(r[7:3] % 5'd3);
            addr = {24'h00_0a11 + 24'h00_1111 * 24'(tsel), 3'b010, r[8], r[2:1], 2'b00};
            data = $random(seed);
            access(r[0], addr, data, lat, rdc, wrc);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/dcache_pkg.sv
hw/dcache_way_if.sv
hw/dcache_way.sv
hw/dcache_victim_select.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
tb/mem_model.sv
tb/tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
# Build the cache testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_dcache -Mdir obj_dir -f filelist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtb_dcache
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
